/* verilog.f */
rv_pkg.sv
rv_hazard_if.sv
rv_decoder.sv
rv_regfile.sv
rv_alu.sv
rv_hazard_unit.sv
rv_stage_reg.sv
rv_core.sv
tb_core_assertions.sv
tb_checker.sv
tb_core.sv

/* tb_core.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_core;
  import rv_pkg::*;

  localparam int rows = 8;
  localparam int prog_len = 8;
  localparam int run_len = prog_len + 12;
  localparam int watchdog_ns = rows * run_len * 4 * 4;

  logic            clk = 1'b0;
  logic            reset, stall;
  logic [xlen-1:0] icache_addr, icache_dout, dcache_addr, dcache_din, dcache_dout, csr;
  logic            icache_re, dcache_re;
  logic [3:0]      dcache_we;

  logic            check, exp_store;
  logic [xlen-1:0] exp_csr, exp_addr, exp_data;
  int              row, errors, checks, progress;

  // program, stall mode, expected csr, expected store
  logic [xlen-1:0] prog_tab [rows][prog_len];
  logic            stall_tab [rows];
  logic [xlen-1:0] csr_tab [rows];
  logic            store_tab [rows];
  logic [xlen-1:0] addr_tab [rows];
  logic [xlen-1:0] data_tab [rows];

  logic [xlen-1:0] prog_mem [prog_len];
  logic [xlen-1:0] dmem [256];

  always #2 clk = ~clk;

  rv_core i_dut (
    .clk         (clk),
    .reset       (reset),
    .icache_addr (icache_addr),
    .icache_re   (icache_re),
    .icache_dout (icache_dout),
    .dcache_addr (dcache_addr),
    .dcache_din  (dcache_din),
    .dcache_we   (dcache_we),
    .dcache_re   (dcache_re),
    .dcache_dout (dcache_dout),
    .stall       (stall),
    .csr         (csr)
  );

  tb_checker u_checker (
    .clk         (clk),
    .reset       (reset),
    .icache_addr (icache_addr),
    .icache_re   (icache_re),
    .dcache_addr (dcache_addr),
    .dcache_din  (dcache_din),
    .dcache_we   (dcache_we),
    .dcache_re   (dcache_re),
    .csr         (csr),
    .check       (check),
    .row         (row),
    .exp_csr     (exp_csr),
    .exp_store   (exp_store),
    .exp_addr    (exp_addr),
    .exp_data    (exp_data),
    .errors      (errors),
    .checks      (checks)
  );

  // instruction encoders
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, op_alu_r};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] sw_instr(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
  endfunction

  function automatic logic [31:0] lui_instr(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, op_lui};
  endfunction

  // f3 001 is csrrw, 101 is csrrwi with src as the immediate
  function automatic logic [31:0] csr_instr(input logic [2:0] f3, input logic [4:0] src,
                                            input logic [4:0] rd);
    return {csr_tohost, src, f3, rd, op_system};
  endfunction

  function automatic logic [xlen-1:0] fetch_word(input logic [xlen-1:0] addr);
    logic [xlen-1:0] offset;
    offset = addr - pc_reset;
    if (offset < prog_len * 4) begin
      return prog_mem[offset[4:2]];
    end
    return instr_nop;
  endfunction

  // caches with one cycle of read latency
  always @(posedge clk) begin
    if (icache_re) begin
      icache_dout <= fetch_word(icache_addr);
    end
  end

  always @(posedge clk) begin
    if (dcache_re) begin
      dcache_dout <= dmem[dcache_addr[9:2]];
    end
    if (dcache_we == 4'hf) begin
      dmem[dcache_addr[9:2]] <= dcache_din;
    end
  end

  task automatic build_table();
    // alu chains at distances 1, 2 and 3
    prog_tab[0] = '{i_type(12'd5, 5'd0, 3'b000, 5'd1, op_alu_i),
                    i_type(12'd7, 5'd1, 3'b000, 5'd2, op_alu_i),
                    r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3),
                    r_type(7'h20, 5'd1, 5'd3, 3'b000, 5'd4),
                    i_type(12'd2, 5'd2, 3'b001, 5'd5, op_alu_i),
                    r_type(7'h00, 5'd5, 5'd4, 3'b100, 5'd6),
                    csr_instr(3'b001, 5'd6, 5'd0),
                    instr_nop};
    csr_tab[0] = 32'h0000_003c;
    // shifts and compares on a negative value
    prog_tab[1] = '{i_type(12'hff0, 5'd0, 3'b000, 5'd1, op_alu_i),
                    i_type(12'h402, 5'd1, 3'b101, 5'd2, op_alu_i),
                    r_type(7'h00, 5'd0, 5'd2, 3'b010, 5'd3),
                    r_type(7'h00, 5'd2, 5'd0, 3'b011, 5'd4),
                    i_type(12'd28, 5'd1, 3'b101, 5'd5, op_alu_i),
                    r_type(7'h00, 5'd5, 5'd3, 3'b110, 5'd6),
                    r_type(7'h00, 5'd4, 5'd6, 3'b000, 5'd7),
                    csr_instr(3'b001, 5'd7, 5'd0)};
    csr_tab[1] = 32'h0000_0010;
    // store, load, then load-use
    prog_tab[2] = '{i_type(12'h100, 5'd0, 3'b000, 5'd1, op_alu_i),
                    lui_instr(20'h12345, 5'd2),
                    i_type(12'h678, 5'd2, 3'b000, 5'd2, op_alu_i),
                    sw_instr(12'd8, 5'd2, 5'd1),
                    i_type(12'd8, 5'd1, 3'b010, 5'd3, op_load),
                    i_type(12'h011, 5'd3, 3'b000, 5'd4, op_alu_i),
                    csr_instr(3'b001, 5'd4, 5'd0),
                    instr_nop};
    csr_tab[2] = 32'h1234_5689;
    // lui, writes to x0, csrrwi and the old csr value
    prog_tab[3] = '{lui_instr(20'habcde, 5'd0),
                    i_type(12'd55, 5'd0, 3'b000, 5'd0, op_alu_i),
                    lui_instr(20'habcde, 5'd5),
                    r_type(7'h00, 5'd0, 5'd5, 3'b000, 5'd6),
                    csr_instr(3'b101, 5'd21, 5'd7),
                    r_type(7'h00, 5'd7, 5'd6, 3'b110, 5'd8),
                    csr_instr(3'b001, 5'd8, 5'd9),
                    sw_instr(12'h040, 5'd9, 5'd0)};
    csr_tab[3] = 32'habcd_e000;
    for (int r = 0; r < 4; r++) begin
      stall_tab[r] = 1'b0;
      store_tab[r] = (r >= 2);
      addr_tab[r]  = (r == 2) ? 32'h0000_0108 : 32'h0000_0040;
      data_tab[r]  = (r == 2) ? 32'h1234_5678 : 32'h0000_0015;
    end
    // same programs again under random stall
    for (int r = 4; r < rows; r++) begin
      prog_tab[r]  = prog_tab[r-4];
      stall_tab[r] = 1'b1;
      csr_tab[r]   = csr_tab[r-4];
      store_tab[r] = store_tab[r-4];
      addr_tab[r]  = addr_tab[r-4];
      data_tab[r]  = data_tab[r-4];
    end
  endtask

  task automatic run_row(input int r);
    @(negedge clk);
    reset = 1'b1;
    stall = 1'b0;
    row   = r;
    prog_mem = prog_tab[r];
    for (int i = 0; i < 256; i++) begin
      dmem[i] = (i * 4) * 32'h9e37_79b9;
    end
    exp_csr   = csr_tab[r];
    exp_store = store_tab[r];
    exp_addr  = addr_tab[r];
    exp_data  = data_tab[r];
    repeat (2) @(negedge clk);
    reset = 1'b0;
    // count only cycles in which the pipeline moves
    progress = 0;
    while (progress < run_len) begin
      stall = stall_tab[r] ? (($urandom % 100) < 30) : 1'b0;
      if (!stall) begin
        progress++;
      end
      @(negedge clk);
    end
    stall = 1'b0;
    check = 1'b1;
    @(negedge clk);
    check = 1'b0;
  endtask

  initial begin
    reset       = 1'b1;
    stall       = 1'b0;
    icache_dout = instr_nop;
    dcache_dout = '0;
    check       = 1'b0;
    row         = 0;
    exp_csr     = '0;
    exp_store   = 1'b0;
    exp_addr    = '0;
    exp_data    = '0;
    void'($urandom(86586));
    build_table();
    for (int r = 0; r < rows; r++) begin
      run_row(r);
    end
    @(negedge clk);
    $display("rows: %0d, checks: %0d, checker errors: %0d, assertion failures: %0d",
             rows, checks, errors, i_dut.u_assertions.fails);
    if (errors == 0 && i_dut.u_assertions.fails == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog: the run did not finish within %0d ns, the pipeline or the loop hung",
             watchdog_ns);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* tb_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_checker (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [rv_pkg::xlen-1:0] icache_addr,
  input  logic                    icache_re,
  input  logic [rv_pkg::xlen-1:0] dcache_addr,
  input  logic [rv_pkg::xlen-1:0] dcache_din,
  input  logic [3:0]              dcache_we,
  input  logic                    dcache_re,
  input  logic [rv_pkg::xlen-1:0] csr,
  input  logic                    check,
  input  int                      row,
  input  logic [rv_pkg::xlen-1:0] exp_csr,
  input  logic                    exp_store,
  input  logic [rv_pkg::xlen-1:0] exp_addr,
  input  logic [rv_pkg::xlen-1:0] exp_data,
  output int                      errors,
  output int                      checks
);
  import rv_pkg::*;

  logic            reset_q = 1'b0;
  int              writes;
  logic [xlen-1:0] wr_addr, wr_data;

  initial begin
    errors = 0;
    checks = 0;
  end

  task automatic compare_value(input string name, input logic [xlen-1:0] actual,
                               input logic [xlen-1:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error at %0t: %s = 0x%08h, expected 0x%08h (row %0d)",
               $time, name, actual, expected, row);
    end
  endtask

  task automatic compare_store();
    if (exp_store && writes != 1) begin
      errors++;
      $display("row %0d: expected exactly one data cache write but saw %0d", row, writes);
    end else if (!exp_store && writes != 0) begin
      errors++;
      $display("row %0d: no data cache write expected but saw %0d", row, writes);
    end else if (exp_store) begin
      compare_value("dcache_addr", wr_addr, exp_addr);
      compare_value("dcache_din", wr_data, exp_data);
    end
  endtask

  always @(posedge clk) begin
    // second reset cycle sees the state left by the first
    if (reset && reset_q) begin
      compare_value("csr", csr, '0);
      compare_value("icache_addr", icache_addr, pc_reset);
      compare_value("icache_re", xlen'(icache_re), xlen'(1));
      compare_value("dcache_re", xlen'(dcache_re), '0);
      compare_value("dcache_we", xlen'(dcache_we), '0);
    end
    if (check) begin
      compare_value("csr", csr, exp_csr);
      compare_store();
    end
    if (reset) begin
      writes <= 0;
    end else if (dcache_we != 4'h0) begin
      writes  <= writes + 1;
      wr_addr <= dcache_addr;
      wr_data <= dcache_din;
    end
    reset_q <= reset;
  end

endmodule

`default_nettype wire

/* tb_core_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_core_assertions (
  input logic                    clk,
  input logic                    reset,
  input logic                    stall,
  input logic [rv_pkg::xlen-1:0] icache_addr,
  input logic [rv_pkg::xlen-1:0] dcache_addr,
  input logic [3:0]              dcache_we,
  input logic                    dcache_re,
  input logic [rv_pkg::xlen-1:0] csr
);

  // failed assertions so far
  int fails = 0;

  // stores always write the whole word at a word address
  we_all_or_none: assert property (@(posedge clk) disable iff (reset)
    dcache_we == 4'h0 || (dcache_we == 4'hf && dcache_addr[1:0] == 2'b00))
    else begin
      fails++;
      $error("dcache_we = %b at address 0x%08h is not a full aligned word write",
             dcache_we, dcache_addr);
    end

  re_we_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(dcache_re && dcache_we != 4'h0))
    else begin
      fails++;
      $error("dcache_re and dcache_we are high in the same cycle");
    end

  // frozen pipe leaves the data cache alone and repeats the fetch address
  quiet_on_stall: assert property (@(posedge clk) disable iff (reset)
    stall |-> (!dcache_re && dcache_we == 4'h0 && icache_addr == $past(icache_addr)))
    else begin
      fails++;
      $error("data cache access or new fetch address while stall is high");
    end

  csr_frozen: assert property (@(posedge clk) disable iff (reset)
    stall |=> csr == $past(csr))
    else begin
      fails++;
      $error("csr changed at the end of a stall cycle");
    end

endmodule

bind rv_core tb_core_assertions u_assertions (
  .clk         (clk),
  .reset       (reset),
  .stall       (stall),
  .icache_addr (icache_addr),
  .dcache_addr (dcache_addr),
  .dcache_we   (dcache_we),
  .dcache_re   (dcache_re),
  .csr         (csr)
);

`default_nettype wire

/* rv_core.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_core (
  input  logic                    clk,
  input  logic                    reset,
  output logic [rv_pkg::xlen-1:0] icache_addr,
  output logic                    icache_re,
  input  logic [rv_pkg::xlen-1:0] icache_dout,
  output logic [rv_pkg::xlen-1:0] dcache_addr,
  output logic [rv_pkg::xlen-1:0] dcache_din,
  output logic [3:0]              dcache_we,
  output logic                    dcache_re,
  input  logic [rv_pkg::xlen-1:0] dcache_dout,
  input  logic                    stall,
  output logic [rv_pkg::xlen-1:0] csr
);
  import rv_pkg::*;

  logic [xlen-1:0]       pc, pc_id;
  logic                  id_valid;
  logic                  front_hold;
  logic [xlen-1:0]       instr_id;
  logic [reg_addr_w-1:0] rs1_id, rs2_id;
  ctrl_t                 ctrl_id;
  logic [xlen-1:0]       imm_id, rs1_data_id, rs2_data_id;
  id_ex_t                id_ex_d, id_ex_q;
  ex_mem_t               ex_mem_d, ex_mem_q;
  mem_wb_t               mem_wb_d, mem_wb_q;
  logic [xlen-1:0]       op_a, op_b, alu_b, alu_result;
  logic [xlen-1:0]       mem_result, wb_data;

  rv_hazard_if hz_if ();

  function automatic logic [xlen-1:0] fwd_mux(input fwd_sel_t sel, input logic [xlen-1:0] reg_val,
                                              input logic [xlen-1:0] mem_val,
                                              input logic [xlen-1:0] wb_val);
    logic [xlen-1:0] val;
    case (sel)
      fwd_mem: val = mem_val;
      fwd_wb:  val = wb_val;
      default: val = reg_val;
    endcase
    return val;
  endfunction

  // fetch, pc and the id slot freeze on either kind of stall
  assign front_hold = stall | hz_if.load_stall;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc       <= pc_reset;
      pc_id    <= pc_reset;
      id_valid <= 1'b0;
    end else if (!front_hold) begin
      pc       <= pc + xlen'(4);
      pc_id    <= pc;
      id_valid <= 1'b1;
    end
  end

  // re-read the id address while held so icache_dout still matches id
  assign icache_addr = front_hold ? pc_id : pc;
  assign icache_re   = 1'b1;

  // first cycle after reset decodes a bubble
  assign instr_id = id_valid ? icache_dout : instr_nop;
  assign rs1_id   = instr_id[19:15];
  assign rs2_id   = instr_id[24:20];

  rv_decoder u_decoder (
    .instr (instr_id),
    .ctrl  (ctrl_id),
    .imm   (imm_id)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .reset    (reset),
    .rs1      (rs1_id),
    .rs2      (rs2_id),
    .rd       (mem_wb_q.rd),
    .we       (mem_wb_q.ctrl.reg_we & ~stall),
    .wdata    (wb_data),
    .rs1_data (rs1_data_id),
    .rs2_data (rs2_data_id)
  );

  always_comb begin
    id_ex_d.ctrl = ctrl_id;
    id_ex_d.rd   = instr_id[11:7];
    id_ex_d.rs1  = rs1_id;
    id_ex_d.rs2  = rs2_id;
    // csrrwi carries its immediate in the rs1 field
    id_ex_d.a    = ctrl_id.csr_is_imm ? {{(xlen-5){1'b0}}, rs1_id} : rs1_data_id;
    id_ex_d.b    = rs2_data_id;
    id_ex_d.imm  = imm_id;
  end

  rv_stage_reg #(.payload_t(id_ex_t)) u_id_ex (
    .clk    (clk),
    .reset  (reset),
    .hold   (stall),
    .bubble (hz_if.load_stall),
    .d      (id_ex_d),
    .q      (id_ex_q)
  );

  // execute
  assign op_a  = fwd_mux(hz_if.fwd_a, id_ex_q.a, mem_result, wb_data);
  assign op_b  = fwd_mux(hz_if.fwd_b, id_ex_q.b, mem_result, wb_data);
  assign alu_b = id_ex_q.ctrl.b_is_imm ? id_ex_q.imm : op_b;

  rv_alu u_alu (
    .a      (op_a),
    .b      (alu_b),
    .op     (id_ex_q.ctrl.alu_op),
    .result (alu_result)
  );

  always_comb begin
    ex_mem_d.ctrl       = id_ex_q.ctrl;
    ex_mem_d.rd         = id_ex_q.rd;
    ex_mem_d.alu_result = alu_result;
    ex_mem_d.wdata      = id_ex_q.ctrl.csr_write ? op_a : op_b;
  end

  rv_stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
    .clk    (clk),
    .reset  (reset),
    .hold   (stall),
    .bubble (1'b0),
    .d      (ex_mem_d),
    .q      (ex_mem_q)
  );

  // memory stage does full-word accesses only
  assign dcache_addr = ex_mem_q.alu_result;
  assign dcache_din  = ex_mem_q.wdata;
  assign dcache_re   = ex_mem_q.ctrl.mem_read & ~stall;
  assign dcache_we   = {4{ex_mem_q.ctrl.mem_write & ~stall}};

  // csr instructions return the old csr value
  assign mem_result = ex_mem_q.ctrl.csr_write ? csr : ex_mem_q.alu_result;

  always_ff @(posedge clk) begin
    if (reset) begin
      csr <= '0;
    end else if (!stall && ex_mem_q.ctrl.csr_write) begin
      csr <= ex_mem_q.wdata;
    end
  end

  always_comb begin
    mem_wb_d.ctrl   = ex_mem_q.ctrl;
    mem_wb_d.rd     = ex_mem_q.rd;
    mem_wb_d.result = mem_result;
  end

  rv_stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
    .clk    (clk),
    .reset  (reset),
    .hold   (stall),
    .bubble (1'b0),
    .d      (mem_wb_d),
    .q      (mem_wb_q)
  );

  // load data in wb holds while dcache_re is low
  assign wb_data = mem_wb_q.ctrl.mem_read ? dcache_dout : mem_wb_q.result;

  // hazard detection inputs
  assign hz_if.id_rs1       = rs1_id;
  assign hz_if.id_rs2       = rs2_id;
  assign hz_if.id_use_rs1   = ctrl_id.use_rs1;
  assign hz_if.id_use_rs2   = ctrl_id.use_rs2;
  assign hz_if.ex_rs1       = id_ex_q.rs1;
  assign hz_if.ex_rs2       = id_ex_q.rs2;
  assign hz_if.ex_use_rs1   = id_ex_q.ctrl.use_rs1;
  assign hz_if.ex_use_rs2   = id_ex_q.ctrl.use_rs2;
  assign hz_if.rd_ex        = id_ex_q.rd;
  assign hz_if.mem_read_ex  = id_ex_q.ctrl.mem_read;
  assign hz_if.rd_mem       = ex_mem_q.rd;
  assign hz_if.reg_we_mem   = ex_mem_q.ctrl.reg_we;
  assign hz_if.mem_read_mem = ex_mem_q.ctrl.mem_read;
  assign hz_if.rd_wb        = mem_wb_q.rd;
  assign hz_if.reg_we_wb    = mem_wb_q.ctrl.reg_we;

  rv_hazard_unit u_hazard (
    .hz (hz_if.hazard)
  );

endmodule

`default_nettype wire

/* rv_stage_reg.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     hold,
  input  logic     bubble,
  input  payload_t d,
  output payload_t q
);

  // a cleared payload has all-zero control and so writes nothing
  always_ff @(posedge clk) begin
    if (reset) begin
      q <= '0;
    end else if (hold) begin
      q <= q;
    end else if (bubble) begin
      q <= '0;
    end else begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

/* rv_hazard_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_hazard_unit (
  rv_hazard_if.hazard hz
);
  import rv_pkg::*;

  // mem wins over wb since it holds the younger producer
  // a load in mem is skipped because the load-use stall keeps that case from arising
  function automatic fwd_sel_t pick_fwd(input logic use_rs, input logic [reg_addr_w-1:0] rs);
    fwd_sel_t sel;
    sel = fwd_reg;
    if (use_rs && rs != '0) begin
      if (hz.reg_we_mem && !hz.mem_read_mem && hz.rd_mem == rs) begin
        sel = fwd_mem;
      end else if (hz.reg_we_wb && hz.rd_wb == rs) begin
        sel = fwd_wb;
      end
    end
    return sel;
  endfunction

  always_comb begin
    hz.fwd_a = pick_fwd(hz.ex_use_rs1, hz.ex_rs1);
    hz.fwd_b = pick_fwd(hz.ex_use_rs2, hz.ex_rs2);
  end

  // load in ex feeding the instruction in id
  assign hz.load_stall = hz.mem_read_ex && hz.rd_ex != '0 &&
                         ((hz.id_use_rs1 && hz.id_rs1 == hz.rd_ex) ||
                          (hz.id_use_rs2 && hz.id_rs2 == hz.rd_ex));

endmodule

`default_nettype wire

/* rv_alu.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_alu (
  input  logic [rv_pkg::xlen-1:0] a,
  input  logic [rv_pkg::xlen-1:0] b,
  input  rv_pkg::alu_op_t         op,
  output logic [rv_pkg::xlen-1:0] result
);
  import rv_pkg::*;

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      alu_add:    result = a + b;
      alu_sub:    result = a - b;
      alu_and:    result = a & b;
      alu_or:     result = a | b;
      alu_xor:    result = a ^ b;
      alu_slt:    result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
      alu_sltu:   result = {{(xlen-1){1'b0}}, a < b};
      alu_sll:    result = a << shamt;
      alu_srl:    result = a >> shamt;
      alu_sra:    result = xlen'($signed(a) >>> shamt);
      // lui
      alu_pass_b: result = b;
      default:    result = a + b;
    endcase
  end

endmodule

`default_nettype wire

/* rv_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_regfile (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [rv_pkg::reg_addr_w-1:0] rs1,
  input  logic [rv_pkg::reg_addr_w-1:0] rs2,
  input  logic [rv_pkg::reg_addr_w-1:0] rd,
  input  logic                          we,
  input  logic [rv_pkg::xlen-1:0]       wdata,
  output logic [rv_pkg::xlen-1:0]       rs1_data,
  output logic [rv_pkg::xlen-1:0]       rs2_data
);
  import rv_pkg::*;

  // x0 has no storage
  logic [xlen-1:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // write-first bypass lets id see the value wb writes this cycle
  assign rs1_data = (rs1 == '0) ? '0 : (we && rd == rs1) ? wdata : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : (we && rd == rs2) ? wdata : regs[rs2];

endmodule

`default_nettype wire

/* rv_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_decoder (
  input  logic [rv_pkg::xlen-1:0] instr,
  output rv_pkg::ctrl_t           ctrl,
  output logic [rv_pkg::xlen-1:0] imm
);
  import rv_pkg::*;

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic            f7_bit30;
  logic [xlen-1:0] imm_i, imm_s, imm_u;
  alu_op_t         alu_op_f3;

  assign opcode   = instr[6:0];
  assign funct3   = instr[14:12];
  assign f7_bit30 = instr[30];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_u = {instr[31:12], 12'b0};

  // funct3 map shared by r and i types
  // sub is picked in the r-type branch
  always_comb begin
    case (funct3)
      3'b000:  alu_op_f3 = alu_add;
      3'b001:  alu_op_f3 = alu_sll;
      3'b010:  alu_op_f3 = alu_slt;
      3'b011:  alu_op_f3 = alu_sltu;
      3'b100:  alu_op_f3 = alu_xor;
      3'b101:  alu_op_f3 = f7_bit30 ? alu_sra : alu_srl;
      3'b110:  alu_op_f3 = alu_or;
      default: alu_op_f3 = alu_and;
    endcase
  end

  always_comb begin
    ctrl = '0;
    imm  = '0;
    case (opcode)
      op_lui: begin
        ctrl.reg_we   = 1'b1;
        ctrl.b_is_imm = 1'b1;
        ctrl.alu_op   = alu_pass_b;
        imm           = imm_u;
      end
      op_alu_r: begin
        ctrl.reg_we  = 1'b1;
        ctrl.use_rs1 = 1'b1;
        ctrl.use_rs2 = 1'b1;
        ctrl.alu_op  = (funct3 == 3'b000 && f7_bit30) ? alu_sub : alu_op_f3;
      end
      op_alu_i: begin
        ctrl.reg_we   = 1'b1;
        ctrl.use_rs1  = 1'b1;
        ctrl.b_is_imm = 1'b1;
        ctrl.alu_op   = alu_op_f3;
        imm           = imm_i;
      end
      op_load: begin
        // word loads only
        if (funct3 == 3'b010) begin
          ctrl.reg_we   = 1'b1;
          ctrl.mem_read = 1'b1;
          ctrl.use_rs1  = 1'b1;
          ctrl.b_is_imm = 1'b1;
          imm           = imm_i;
        end
      end
      op_store: begin
        if (funct3 == 3'b010) begin
          ctrl.mem_write = 1'b1;
          ctrl.use_rs1   = 1'b1;
          ctrl.use_rs2   = 1'b1;
          ctrl.b_is_imm  = 1'b1;
          imm            = imm_s;
        end
      end
      op_system: begin
        // csrrw and csrrwi on tohost only
        // rd gets the old csr value
        if (instr[31:20] == csr_tohost && funct3[1:0] == 2'b01) begin
          ctrl.reg_we     = 1'b1;
          ctrl.csr_write  = 1'b1;
          ctrl.csr_is_imm = funct3[2];
          ctrl.use_rs1    = ~funct3[2];
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* rv_hazard_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface rv_hazard_if;

  // source registers of the instructions in id and ex
  logic [rv_pkg::reg_addr_w-1:0] id_rs1, id_rs2, ex_rs1, ex_rs2;
  logic id_use_rs1, id_use_rs2, ex_use_rs1, ex_use_rs2;

  // destinations further down the pipe
  logic [rv_pkg::reg_addr_w-1:0] rd_ex, rd_mem, rd_wb;
  logic mem_read_ex, reg_we_mem, mem_read_mem, reg_we_wb;

  rv_pkg::fwd_sel_t fwd_a, fwd_b;
  logic load_stall;

  modport producer (
    output id_rs1, id_rs2, ex_rs1, ex_rs2, id_use_rs1, id_use_rs2, ex_use_rs1, ex_use_rs2,
    output rd_ex, rd_mem, rd_wb, mem_read_ex, reg_we_mem, mem_read_mem, reg_we_wb
  );

  modport hazard (
    input  id_rs1, id_rs2, ex_rs1, ex_rs2, id_use_rs1, id_use_rs2, ex_use_rs1, ex_use_rs2,
    input  rd_ex, rd_mem, rd_wb, mem_read_ex, reg_we_mem, mem_read_mem, reg_we_wb,
    output fwd_a, fwd_b, load_stall
  );

  modport stage (input fwd_a, fwd_b, load_stall);

endinterface

`default_nettype wire

/* rv_pkg.sv */
`default_nettype none

package rv_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;

  localparam logic [xlen-1:0] pc_reset = 32'h0000_2000;
  // the only implemented csr
  // any other csr address decodes as a nop
  localparam logic [11:0] csr_tohost = 12'h51e;

  // rv32i major opcodes
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_alu_r  = 7'b0110011;
  localparam logic [6:0] op_alu_i  = 7'b0010011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_system = 7'b1110011;

  // addi x0, x0, 0
  localparam logic [xlen-1:0] instr_nop = 32'h0000_0013;

  // alu_add must stay at zero so a cleared ctrl is a harmless add
  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_sltu,
    alu_sll, alu_srl, alu_sra, alu_pass_b
  } alu_op_t;

  typedef enum logic [1:0] {fwd_reg, fwd_mem, fwd_wb} fwd_sel_t;

  typedef struct packed {
    logic    reg_we;
    logic    mem_read;
    logic    mem_write;
    logic    csr_write;
    logic    use_rs1;
    logic    use_rs2;
    logic    b_is_imm;
    logic    csr_is_imm;
    alu_op_t alu_op;
  } ctrl_t;

  // a holds the rs1 value, or the zero-extended csrrwi immediate
  typedef struct packed {
    ctrl_t                 ctrl;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [xlen-1:0]       a;
    logic [xlen-1:0]       b;
    logic [xlen-1:0]       imm;
  } id_ex_t;

  // wdata is store data, or the new csr value
  typedef struct packed {
    ctrl_t                 ctrl;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       alu_result;
    logic [xlen-1:0]       wdata;
  } ex_mem_t;

  typedef struct packed {
    ctrl_t                 ctrl;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       result;
  } mem_wb_t;

endpackage

`default_nettype wire
